//--- verilog/rs_pkg.sv
package rs_pkg;

    localparam int PHYS_TAG_W = 6;  // 64 physical registers
    localparam int ARCH_REG_W = 5;
    localparam int ROB_IDX_W  = 6;

    typedef logic [PHYS_TAG_W-1:0] phys_tag_t;
    typedef logic [ARCH_REG_W-1:0] arch_reg_t;
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;

    // dispatched micro-op, upper two bits pick the station
    typedef enum logic [3:0] {
        UOP_ADD    = 4'd0,
        UOP_SUB    = 4'd1,
        UOP_AND    = 4'd2,
        UOP_OR     = 4'd3,
        UOP_XOR    = 4'd4,
        UOP_SLL    = 4'd5,
        UOP_SRL    = 4'd6,
        UOP_SRA    = 4'd7,
        UOP_MUL    = 4'd8,   // multiply station from here
        UOP_MULH   = 4'd9,
        UOP_MULHSU = 4'd10,
        UOP_MULHU  = 4'd11,
        UOP_DIV    = 4'd12,  // divide station from here
        UOP_DIVU   = 4'd13,
        UOP_REM    = 4'd14,
        UOP_REMU   = 4'd15
    } uop_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_t;

    // one variant code for both the multiplier and the divider
    typedef enum logic [1:0] {
        MD_MUL_DIV    = 2'd0,
        MD_MULH_DIVU  = 2'd1,
        MD_MULHSU_REM = 2'd2,
        MD_MULHU_REMU = 2'd3
    } md_op_t;

    typedef struct packed {
        phys_tag_t pd;
        arch_reg_t rd;
        rob_idx_t  rob;
        alu_op_t   op;
    } alu_payload_t;  // 20 bits

    typedef struct packed {
        phys_tag_t pd;
        arch_reg_t rd;
        rob_idx_t  rob;
        md_op_t    op;
    } md_payload_t;  // 19 bits

    // true when any valid broadcast carries this tag
    function automatic logic cdb_hit(
        input phys_tag_t tag,
        input logic      alu_valid,
        input phys_tag_t alu_tag,
        input logic      mul_valid,
        input phys_tag_t mul_tag,
        input logic      div_valid,
        input phys_tag_t div_tag
    );
        return (alu_valid && (alu_tag == tag))
            || (mul_valid && (mul_tag == tag))
            || (div_valid && (div_tag == tag));
    endfunction

endpackage

//--- verilog/rs_dispatch.sv
`timescale 1ns/1ps

module rs_dispatch
    import rs_pkg::*;
(
    input  logic         dispatch_valid,  // single-cycle strobe
    input  uop_t         uop,
    input  phys_tag_t    ps1,
    input  phys_tag_t    ps2,
    input  logic         ps1_ready,       // ready bits from rename
    input  logic         ps2_ready,
    input  phys_tag_t    pd,
    input  arch_reg_t    rd,
    input  rob_idx_t     rob,
    input  logic         cdb_alu_valid,
    input  phys_tag_t    cdb_alu_tag,
    input  logic         cdb_mul_valid,
    input  phys_tag_t    cdb_mul_tag,
    input  logic         cdb_div_valid,
    input  phys_tag_t    cdb_div_tag,
    input  logic         alu_full,
    input  logic         mul_full,
    input  logic         div_full,
    output logic         alu_insert,
    output logic         mul_insert,
    output logic         div_insert,
    output logic         src1_ready,
    output logic         src2_ready,
    output alu_payload_t alu_payload,
    output md_payload_t  md_payload   // shared by mul and div stations
);

    logic [3:0] uop_bits;
    logic       to_alu;
    logic       to_mul;
    logic       to_div;

    assign uop_bits = uop;

    // station routing from the top two bits
    always_comb
    begin
        to_alu = 1'b0;
        to_mul = 1'b0;
        to_div = 1'b0;
        case (uop_bits[3:2])
            2'b10:   to_mul = 1'b1;
            2'b11:   to_div = 1'b1;
            default: to_alu = 1'b1;  // codes 0..7
        endcase
    end

    // micro-op lost when its station is full
    assign alu_insert = dispatch_valid && to_alu && !alu_full;
    assign mul_insert = dispatch_valid && to_mul && !mul_full;
    assign div_insert = dispatch_valid && to_div && !div_full;

    // same-cycle bypass, a broadcast now would be missed by the stored entry
    assign src1_ready = ps1_ready || cdb_hit(ps1, cdb_alu_valid, cdb_alu_tag,
                                             cdb_mul_valid, cdb_mul_tag,
                                             cdb_div_valid, cdb_div_tag);
    assign src2_ready = ps2_ready || cdb_hit(ps2, cdb_alu_valid, cdb_alu_tag,
                                             cdb_mul_valid, cdb_mul_tag,
                                             cdb_div_valid, cdb_div_tag);

    // payloads built for every station, only the strobed one takes it
    always_comb
    begin
        alu_payload.pd  = pd;
        alu_payload.rd  = rd;
        alu_payload.rob = rob;
        alu_payload.op  = alu_op_t'(uop_bits[2:0]);  // lower three bits
        md_payload.pd   = pd;
        md_payload.rd   = rd;
        md_payload.rob  = rob;
        md_payload.op   = md_op_t'(uop_bits[1:0]);   // variant within mul or div
    end

endmodule

//--- verilog/rs_station.sv
`timescale 1ns/1ps

module rs_station
    import rs_pkg::*;
#(
    parameter int  DEPTH     = 4,
    parameter type payload_t = alu_payload_t
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      insert,            // gated by full upstream
    input  phys_tag_t insert_ps1,
    input  phys_tag_t insert_ps2,
    input  logic      insert_ps1_ready,  // already bypassed
    input  logic      insert_ps2_ready,
    input  payload_t  insert_payload,
    input  logic      cdb_alu_valid,
    input  phys_tag_t cdb_alu_tag,
    input  logic      cdb_mul_valid,
    input  phys_tag_t cdb_mul_tag,
    input  logic      cdb_div_valid,
    input  phys_tag_t cdb_div_tag,
    input  logic      fu_busy,
    output logic      full,
    output logic      issue,
    output phys_tag_t issue_ps1,
    output phys_tag_t issue_ps2,
    output payload_t  issue_payload
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // entry state
    logic [DEPTH-1:0] busy_q;  // entry holds a micro-op
    logic [DEPTH-1:0] rdy1_q;
    logic [DEPTH-1:0] rdy2_q;
    phys_tag_t        ps1_q [DEPTH];
    phys_tag_t        ps2_q [DEPTH];
    payload_t         payload_q [DEPTH];

    logic [DEPTH-1:0] entry_ready;  // busy with both sources ready
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] sel_idx;

    // full only from stored busy bits
    assign full = &busy_q;

    always_comb
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            entry_ready[i] = busy_q[i] && rdy1_q[i] && rdy2_q[i];
        end
    end

    // lowest free slot, scanned high to low so the last hit wins
    always_comb
    begin
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--)
        begin
            if (!busy_q[i])
                free_idx = IDX_W'(i);
        end
    end

    // lowest ready entry, same scan
    always_comb
    begin
        sel_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--)
        begin
            if (entry_ready[i])
                sel_idx = IDX_W'(i);
        end
    end

    assign issue = !fu_busy && (|entry_ready);  // busy unit holds every entry

    // fields zero when nothing issues
    always_comb
    begin
        issue_ps1     = '0;
        issue_ps2     = '0;
        issue_payload = '0;
        if (issue)
        begin
            issue_ps1     = ps1_q[sel_idx];
            issue_ps2     = ps2_q[sel_idx];
            issue_payload = payload_q[sel_idx];
        end
    end

    // busy bits, issued slot freed at the end of the cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy_q <= '0;
        end
        else
        begin
            if (issue)
                busy_q[sel_idx] <= 1'b0;
            if (insert)
                busy_q[free_idx] <= 1'b1;  // free at cycle start, never the issued slot
        end
    end

    // wakeup and insert, the written slot is not busy so no overlap
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            if (busy_q[i] && !rdy1_q[i]
                && cdb_hit(ps1_q[i], cdb_alu_valid, cdb_alu_tag,
                           cdb_mul_valid, cdb_mul_tag, cdb_div_valid, cdb_div_tag))
                rdy1_q[i] <= 1'b1;
            if (busy_q[i] && !rdy2_q[i]
                && cdb_hit(ps2_q[i], cdb_alu_valid, cdb_alu_tag,
                           cdb_mul_valid, cdb_mul_tag, cdb_div_valid, cdb_div_tag))
                rdy2_q[i] <= 1'b1;
        end
        if (insert)
        begin
            ps1_q[free_idx]     <= insert_ps1;
            ps2_q[free_idx]     <= insert_ps2;
            rdy1_q[free_idx]    <= insert_ps1_ready;
            rdy2_q[free_idx]    <= insert_ps2_ready;
            payload_q[free_idx] <= insert_payload;
        end
    end

endmodule

//--- verilog/reservation_stations.sv
`timescale 1ns/1ps

module reservation_stations
    import rs_pkg::*;
#(
    parameter int ALU_DEPTH = 4,
    parameter int MUL_DEPTH = 2,
    parameter int DIV_DEPTH = 2
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      dispatch_valid,
    input  uop_t      uop,
    input  phys_tag_t ps1,
    input  phys_tag_t ps2,
    input  logic      ps1_ready,
    input  logic      ps2_ready,
    input  phys_tag_t pd,
    input  arch_reg_t rd,
    input  rob_idx_t  rob,
    input  logic      cdb_alu_valid,
    input  phys_tag_t cdb_alu_tag,
    input  logic      cdb_mul_valid,
    input  phys_tag_t cdb_mul_tag,
    input  logic      cdb_div_valid,
    input  phys_tag_t cdb_div_tag,
    input  logic      alu_fu_busy,
    input  logic      mul_fu_busy,
    input  logic      div_fu_busy,
    output logic      alu_full,
    output logic      mul_full,
    output logic      div_full,
    output logic      alu_issue,
    output phys_tag_t alu_ps1,
    output phys_tag_t alu_ps2,
    output phys_tag_t alu_pd,
    output arch_reg_t alu_rd,
    output rob_idx_t  alu_rob,
    output alu_op_t   alu_op,
    output logic      mul_issue,
    output phys_tag_t mul_ps1,
    output phys_tag_t mul_ps2,
    output phys_tag_t mul_pd,
    output arch_reg_t mul_rd,
    output rob_idx_t  mul_rob,
    output md_op_t    mul_op,
    output logic      div_issue,
    output phys_tag_t div_ps1,
    output phys_tag_t div_ps2,
    output phys_tag_t div_pd,
    output arch_reg_t div_rd,
    output rob_idx_t  div_rob,
    output md_op_t    div_op
);

    logic         alu_insert;
    logic         mul_insert;
    logic         div_insert;
    logic         src1_ready;  // after bypass
    logic         src2_ready;
    alu_payload_t alu_payload;
    md_payload_t  md_payload;
    alu_payload_t alu_issue_payload;
    md_payload_t  mul_issue_payload;
    md_payload_t  div_issue_payload;

    rs_dispatch i_rs_dispatch (
        .dispatch_valid (dispatch_valid),
        .uop            (uop),
        .ps1            (ps1),
        .ps2            (ps2),
        .ps1_ready      (ps1_ready),
        .ps2_ready      (ps2_ready),
        .pd             (pd),
        .rd             (rd),
        .rob            (rob),
        .cdb_alu_valid  (cdb_alu_valid),
        .cdb_alu_tag    (cdb_alu_tag),
        .cdb_mul_valid  (cdb_mul_valid),
        .cdb_mul_tag    (cdb_mul_tag),
        .cdb_div_valid  (cdb_div_valid),
        .cdb_div_tag    (cdb_div_tag),
        .alu_full       (alu_full),
        .mul_full       (mul_full),
        .div_full       (div_full),
        .alu_insert     (alu_insert),
        .mul_insert     (mul_insert),
        .div_insert     (div_insert),
        .src1_ready     (src1_ready),
        .src2_ready     (src2_ready),
        .alu_payload    (alu_payload),
        .md_payload     (md_payload)
    );

    rs_station #(.DEPTH(ALU_DEPTH), .payload_t(alu_payload_t)) i_alu_station (
        .clk(clk), .rst(rst),
        .insert(alu_insert), .insert_ps1(ps1), .insert_ps2(ps2),  // tags straight from dispatch
        .insert_ps1_ready(src1_ready), .insert_ps2_ready(src2_ready),
        .insert_payload(alu_payload),
        .cdb_alu_valid(cdb_alu_valid), .cdb_alu_tag(cdb_alu_tag),
        .cdb_mul_valid(cdb_mul_valid), .cdb_mul_tag(cdb_mul_tag),
        .cdb_div_valid(cdb_div_valid), .cdb_div_tag(cdb_div_tag),
        .fu_busy(alu_fu_busy), .full(alu_full), .issue(alu_issue),
        .issue_ps1(alu_ps1), .issue_ps2(alu_ps2), .issue_payload(alu_issue_payload)
    );

    rs_station #(.DEPTH(MUL_DEPTH), .payload_t(md_payload_t)) i_mul_station (
        .clk(clk), .rst(rst),
        .insert(mul_insert), .insert_ps1(ps1), .insert_ps2(ps2),
        .insert_ps1_ready(src1_ready), .insert_ps2_ready(src2_ready),
        .insert_payload(md_payload),
        .cdb_alu_valid(cdb_alu_valid), .cdb_alu_tag(cdb_alu_tag),
        .cdb_mul_valid(cdb_mul_valid), .cdb_mul_tag(cdb_mul_tag),
        .cdb_div_valid(cdb_div_valid), .cdb_div_tag(cdb_div_tag),
        .fu_busy(mul_fu_busy), .full(mul_full), .issue(mul_issue),
        .issue_ps1(mul_ps1), .issue_ps2(mul_ps2), .issue_payload(mul_issue_payload)
    );

    rs_station #(.DEPTH(DIV_DEPTH), .payload_t(md_payload_t)) i_div_station (
        .clk(clk), .rst(rst),
        .insert(div_insert), .insert_ps1(ps1), .insert_ps2(ps2),
        .insert_ps1_ready(src1_ready), .insert_ps2_ready(src2_ready),
        .insert_payload(md_payload),  // same payload as mul, different strobe
        .cdb_alu_valid(cdb_alu_valid), .cdb_alu_tag(cdb_alu_tag),
        .cdb_mul_valid(cdb_mul_valid), .cdb_mul_tag(cdb_mul_tag),
        .cdb_div_valid(cdb_div_valid), .cdb_div_tag(cdb_div_tag),
        .fu_busy(div_fu_busy), .full(div_full), .issue(div_issue),
        .issue_ps1(div_ps1), .issue_ps2(div_ps2), .issue_payload(div_issue_payload)
    );

    // unpack issue payloads
    assign alu_pd  = alu_issue_payload.pd;
    assign alu_rd  = alu_issue_payload.rd;
    assign alu_rob = alu_issue_payload.rob;
    assign alu_op  = alu_issue_payload.op;
    assign mul_pd  = mul_issue_payload.pd;
    assign mul_rd  = mul_issue_payload.rd;
    assign mul_rob = mul_issue_payload.rob;
    assign mul_op  = mul_issue_payload.op;
    assign div_pd  = div_issue_payload.pd;
    assign div_rd  = div_issue_payload.rd;
    assign div_rob = div_issue_payload.rob;
    assign div_op  = div_issue_payload.op;

endmodule

//--- dv/reservation_stations_tb.sv
`timescale 1ns/1ps

module reservation_stations_tb
    import rs_pkg::*;
();

    localparam int ALU_DEPTH      = 4;
    localparam int MUL_DEPTH      = 2;
    localparam int DIV_DEPTH      = 2;
    localparam int MAX_DEPTH      = 4;  // covers the deepest station
    localparam int RANDOM_CYCLES  = 2000;
    localparam int TIMEOUT_CYCLES = RANDOM_CYCLES + 300;  // directed parts need far less

    logic      clk;
    logic      rst;
    logic      dispatch_valid;
    logic [3:0] uop_code;
    phys_tag_t ps1;
    phys_tag_t ps2;
    logic      ps1_ready;
    logic      ps2_ready;
    phys_tag_t pd;
    arch_reg_t rd;
    rob_idx_t  rob;
    logic      cdb_alu_valid;
    phys_tag_t cdb_alu_tag;
    logic      cdb_mul_valid;
    phys_tag_t cdb_mul_tag;
    logic      cdb_div_valid;
    phys_tag_t cdb_div_tag;
    logic      alu_fu_busy;
    logic      mul_fu_busy;
    logic      div_fu_busy;

    // dut outputs indexed by station (0 alu 1 mul 2 div)
    logic       got_issue [3];
    logic       got_full [3];
    phys_tag_t  got_ps1 [3];
    phys_tag_t  got_ps2 [3];
    phys_tag_t  got_pd [3];
    arch_reg_t  got_rd [3];
    rob_idx_t   got_rob [3];
    logic [2:0] got_alu_op;
    logic [1:0] got_mul_op;
    logic [1:0] got_div_op;

    // model entries
    logic       m_busy [3][MAX_DEPTH];
    logic       m_r1 [3][MAX_DEPTH];
    logic       m_r2 [3][MAX_DEPTH];
    phys_tag_t  m_ps1 [3][MAX_DEPTH];
    phys_tag_t  m_ps2 [3][MAX_DEPTH];
    phys_tag_t  m_pd [3][MAX_DEPTH];
    arch_reg_t  m_rd [3][MAX_DEPTH];
    rob_idx_t   m_rob [3][MAX_DEPTH];
    logic [2:0] m_op [3][MAX_DEPTH];

    integer seed;
    int     cycles;

    always #20 clk = ~clk;  // 40 ns period

    reservation_stations #(
        .ALU_DEPTH(ALU_DEPTH),
        .MUL_DEPTH(MUL_DEPTH),
        .DIV_DEPTH(DIV_DEPTH)
    ) i_reservation_stations (
        .clk(clk), .rst(rst),
        .dispatch_valid(dispatch_valid), .uop(uop_t'(uop_code)),
        .ps1(ps1), .ps2(ps2), .ps1_ready(ps1_ready), .ps2_ready(ps2_ready),
        .pd(pd), .rd(rd), .rob(rob),
        .cdb_alu_valid(cdb_alu_valid), .cdb_alu_tag(cdb_alu_tag),
        .cdb_mul_valid(cdb_mul_valid), .cdb_mul_tag(cdb_mul_tag),
        .cdb_div_valid(cdb_div_valid), .cdb_div_tag(cdb_div_tag),
        .alu_fu_busy(alu_fu_busy), .mul_fu_busy(mul_fu_busy), .div_fu_busy(div_fu_busy),
        .alu_full(got_full[0]), .mul_full(got_full[1]), .div_full(got_full[2]),
        .alu_issue(got_issue[0]), .alu_ps1(got_ps1[0]), .alu_ps2(got_ps2[0]),
        .alu_pd(got_pd[0]), .alu_rd(got_rd[0]), .alu_rob(got_rob[0]), .alu_op(got_alu_op),
        .mul_issue(got_issue[1]), .mul_ps1(got_ps1[1]), .mul_ps2(got_ps2[1]),
        .mul_pd(got_pd[1]), .mul_rd(got_rd[1]), .mul_rob(got_rob[1]), .mul_op(got_mul_op),
        .div_issue(got_issue[2]), .div_ps1(got_ps1[2]), .div_ps2(got_ps2[2]),
        .div_pd(got_pd[2]), .div_rd(got_rd[2]), .div_rob(got_rob[2]), .div_op(got_div_op)
    );

    function automatic int depth_of(input int s);
        case (s)
            0:       return ALU_DEPTH;
            1:       return MUL_DEPTH;
            default: return DIV_DEPTH;
        endcase
    endfunction

    function automatic logic fu_busy_of(input int s);
        case (s)
            0:       return alu_fu_busy;
            1:       return mul_fu_busy;
            default: return div_fu_busy;
        endcase
    endfunction

    function automatic string unit_name(input int s);
        case (s)
            0:       return "alu";
            1:       return "mul";
            default: return "div";
        endcase
    endfunction

    function automatic logic [2:0] got_op(input int s);
        case (s)
            0:       return got_alu_op;
            1:       return {1'b0, got_mul_op};
            default: return {1'b0, got_div_op};
        endcase
    endfunction

    // codes 0..7 alu, 8..11 mul, 12..15 div
    function automatic int station_of(input logic [3:0] u);
        return u[3] ? (u[2] ? 2 : 1) : 0;
    endfunction

    function automatic logic tag_seen(input phys_tag_t tag);
        return (cdb_alu_valid && (cdb_alu_tag == tag))
            || (cdb_mul_valid && (cdb_mul_tag == tag))
            || (cdb_div_valid && (cdb_div_tag == tag));
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic model_reset();
        for (int s = 0; s < 3; s++)
            for (int i = 0; i < MAX_DEPTH; i++)
                m_busy[s][i] = 1'b0;
    endtask

    // predict this cycle's outputs and step to the state after the next edge
    task automatic model_cycle();
        int         sel;
        int         free_slot;
        logic       full_s;
        logic       exp_issue;
        phys_tag_t  e_ps1;
        phys_tag_t  e_ps2;
        phys_tag_t  e_pd;
        arch_reg_t  e_rd;
        rob_idx_t   e_rob;
        logic [2:0] e_op;
        for (int s = 0; s < 3; s++)
        begin
            full_s    = 1'b1;
            sel       = -1;
            free_slot = -1;
            for (int i = depth_of(s) - 1; i >= 0; i--)  // downward scan keeps the lowest hit
            begin
                if (!m_busy[s][i])
                begin
                    full_s    = 1'b0;
                    free_slot = i;
                end
                if (m_busy[s][i] && m_r1[s][i] && m_r2[s][i])
                    sel = i;
            end
            exp_issue = !fu_busy_of(s) && (sel >= 0);
            e_ps1 = '0;  // idle fields read as zero
            e_ps2 = '0;
            e_pd  = '0;
            e_rd  = '0;
            e_rob = '0;
            e_op  = '0;
            if (exp_issue)
            begin
                e_ps1 = m_ps1[s][sel];
                e_ps2 = m_ps2[s][sel];
                e_pd  = m_pd[s][sel];
                e_rd  = m_rd[s][sel];
                e_rob = m_rob[s][sel];
                e_op  = m_op[s][sel];
            end
            check({unit_name(s), "_issue"}, 32'(got_issue[s]), 32'(exp_issue));
            check({unit_name(s), "_full"}, 32'(got_full[s]), 32'(full_s));
            check({unit_name(s), "_ps1"}, 32'(got_ps1[s]), 32'(e_ps1));
            check({unit_name(s), "_ps2"}, 32'(got_ps2[s]), 32'(e_ps2));
            check({unit_name(s), "_pd"}, 32'(got_pd[s]), 32'(e_pd));
            check({unit_name(s), "_rd"}, 32'(got_rd[s]), 32'(e_rd));
            check({unit_name(s), "_rob"}, 32'(got_rob[s]), 32'(e_rob));
            check({unit_name(s), "_op"}, 32'(got_op(s)), 32'(e_op));
            for (int i = 0; i < depth_of(s); i++)  // wakeup on current broadcasts
            begin
                if (m_busy[s][i] && tag_seen(m_ps1[s][i]))
                    m_r1[s][i] = 1'b1;
                if (m_busy[s][i] && tag_seen(m_ps2[s][i]))
                    m_r2[s][i] = 1'b1;
            end
            if (exp_issue)
                m_busy[s][sel] = 1'b0;
            if (dispatch_valid && (station_of(uop_code) == s) && !full_s)
            begin
                m_busy[s][free_slot] = 1'b1;
                m_ps1[s][free_slot]  = ps1;
                m_ps2[s][free_slot]  = ps2;
                m_r1[s][free_slot]   = ps1_ready || tag_seen(ps1);  // bypass
                m_r2[s][free_slot]   = ps2_ready || tag_seen(ps2);
                m_pd[s][free_slot]   = pd;
                m_rd[s][free_slot]   = rd;
                m_rob[s][free_slot]  = rob;
                m_op[s][free_slot]   = (s == 0) ? uop_code[2:0] : {1'b0, uop_code[1:0]};
            end
        end
    endtask

    // inputs are stable between rising edges so the falling edge samples them
    always @(negedge clk)
    begin
        if (rst)
            model_reset();
        else
            model_cycle();
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic release_reset();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    // one dispatch cycle with broadcasts cleared unless set after this call
    task automatic send(input logic dv, input logic [3:0] u, input phys_tag_t t1,
                        input phys_tag_t t2, input logic r1, input logic r2,
                        input phys_tag_t dest, input rob_idx_t robi);
        @(posedge clk);
        dispatch_valid <= dv;
        uop_code       <= u;
        ps1            <= t1;
        ps2            <= t2;
        ps1_ready      <= r1;
        ps2_ready      <= r2;
        pd             <= dest;
        rd             <= dest[4:0];
        rob            <= robi;
        cdb_alu_valid  <= 1'b0;
        cdb_mul_valid  <= 1'b0;
        cdb_div_valid  <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) send(1'b0, 4'd0, 6'd0, 6'd0, 1'b0, 1'b0, 6'd0, 6'd0);
    endtask

    // called in the time step of the preceding send so this write wins
    task automatic broadcast(input int port, input logic v, input phys_tag_t tag);
        case (port)
            0:
            begin
                cdb_alu_valid <= v;
                cdb_alu_tag   <= tag;
            end
            1:
            begin
                cdb_mul_valid <= v;
                cdb_mul_tag   <= tag;
            end
            default:
            begin
                cdb_div_valid <= v;
                cdb_div_tag   <= tag;
            end
        endcase
    endtask

    task automatic set_fu_busy(input logic a, input logic m, input logic d);
        alu_fu_busy <= a;
        mul_fu_busy <= m;
        div_fu_busy <= d;
    endtask

    task automatic random_cycle();
        logic [31:0] ra;
        logic [31:0] rb;
        @(posedge clk);
        ra = $random(seed);
        rb = $random(seed);
        dispatch_valid <= ra[0] | ra[1];  // about 3 in 4 cycles
        uop_code       <= ra[5:2];
        ps1            <= {3'b000, ra[8:6]};  // small tag pool so broadcasts hit
        ps2            <= {3'b000, ra[11:9]};
        ps1_ready      <= ra[12];
        ps2_ready      <= ra[13];
        pd             <= ra[19:14];
        rd             <= ra[24:20];
        rob            <= ra[30:25];
        cdb_alu_valid  <= rb[0];
        cdb_alu_tag    <= {3'b000, rb[3:1]};
        cdb_mul_valid  <= rb[4];
        cdb_mul_tag    <= {3'b000, rb[7:5]};
        cdb_div_valid  <= rb[8];
        cdb_div_tag    <= {3'b000, rb[11:9]};
        alu_fu_busy    <= rb[12] & rb[13];
        mul_fu_busy    <= rb[14] & rb[15];
        div_fu_busy    <= rb[16] & rb[17];
    endtask

    initial
    begin
        seed           = 95914;
        cycles         = 0;
        clk            = 1'b0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        uop_code       = 4'd0;
        ps1            = '0;
        ps2            = '0;
        ps1_ready      = 1'b0;
        ps2_ready      = 1'b0;
        pd             = '0;
        rd             = '0;
        rob            = '0;
        cdb_alu_valid  = 1'b0;
        cdb_alu_tag    = '0;
        cdb_mul_valid  = 1'b0;
        cdb_mul_tag    = '0;
        cdb_div_valid  = 1'b0;
        cdb_div_tag    = '0;
        alu_fu_busy    = 1'b0;
        mul_fu_busy    = 1'b0;
        div_fu_busy    = 1'b0;
        release_reset();
        @(negedge clk);
        for (int s = 0; s < 3; s++)  // quiet after reset
        begin
            check({unit_name(s), "_issue after reset"}, 32'(got_issue[s]), 32'd0);
            check({unit_name(s), "_full after reset"}, 32'(got_full[s]), 32'd0);
        end
        // every micro-op with both sources ready issues one cycle later
        for (int u = 0; u < 16; u++)
            send(1'b1, 4'(u), 6'(u + 1), 6'(u + 17), 1'b1, 1'b1, 6'(u + 33), 6'(u));
        idle_cycles(3);
        // wakeup after an invalid matching broadcast
        send(1'b1, 4'd4, 6'd21, 6'd22, 1'b0, 1'b1, 6'd40, 6'd40);
        send(1'b0, 4'd0, 6'd0, 6'd0, 1'b0, 1'b0, 6'd0, 6'd0);
        broadcast(1, 1'b0, 6'd21);
        idle_cycles(1);
        send(1'b0, 4'd0, 6'd0, 6'd0, 1'b0, 1'b0, 6'd0, 6'd0);
        broadcast(2, 1'b1, 6'd21);
        idle_cycles(2);
        // both sources caught by the bypass
        send(1'b1, 4'd11, 6'd30, 6'd31, 1'b0, 1'b0, 6'd41, 6'd41);
        broadcast(0, 1'b1, 6'd30);
        broadcast(1, 1'b1, 6'd31);
        idle_cycles(2);
        // one source by bypass and the other by a later wakeup
        send(1'b1, 4'd14, 6'd33, 6'd34, 1'b0, 1'b0, 6'd42, 6'd42);
        broadcast(0, 1'b1, 6'd33);
        send(1'b0, 4'd0, 6'd0, 6'd0, 1'b0, 1'b0, 6'd0, 6'd0);
        broadcast(2, 1'b1, 6'd34);
        idle_cycles(2);
        // fill each station under busy and drop one more before the drain
        for (int s = 0; s < 3; s++)
        begin
            set_fu_busy(s == 0, s == 1, s == 2);
            for (int k = 0; k < depth_of(s); k++)
                send(1'b1, 4'((s == 0) ? k : 4 * s + 4 + k), 6'(k + 50), 6'(k + 55),
                     1'b1, 1'b1, 6'(k + 8), 6'(32 + 8 * s + k));
            idle_cycles(1);
            @(negedge clk);
            check({unit_name(s), "_full when filled"}, 32'(got_full[s]), 32'd1);
            send(1'b1, 4'((s == 0) ? 3 : 4 * s + 4), 6'd60, 6'd61, 1'b1, 1'b1,
                 6'd62, 6'h3f);  // rob 3f must never issue
            idle_cycles(1);
            set_fu_busy(1'b0, 1'b0, 1'b0);
            idle_cycles(depth_of(s) + 2);
        end
        repeat (RANDOM_CYCLES) random_cycle();
        set_fu_busy(1'b0, 1'b0, 1'b0);
        idle_cycles(2);
        @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- flist.f
verilog/rs_pkg.sv
verilog/rs_dispatch.sv
verilog/rs_station.sv
verilog/reservation_stations.sv
dv/reservation_stations_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module reservation_stations_tb \
    -f flist.f -o reservation_stations_sim

status=0
out=$(./obj_dir/reservation_stations_sim 2>&1) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -q "STATUS: PASS"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
